// File: design/exe_pkg.sv
package exe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // byte size of one instruction
    localparam word_t link_offset = 32'd4;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_nor,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    typedef enum logic [3:0] {
        br_jirl = 4'd3,
        br_b    = 4'd4,
        br_bl   = 4'd5,
        br_beq  = 4'd6,
        br_bne  = 4'd7,
        br_blt  = 4'd8,
        br_bge  = 4'd9,
        br_bltu = 4'd10,
        br_bgeu = 4'd11
    } br_cond_e;

    typedef enum logic [1:0] {
        cat_cond,
        cat_jump,
        cat_call,
        cat_return
    } br_cat_e;

    // lane 0 only, lane 1 is always alu
    typedef enum logic [1:0] {
        unit_none,
        unit_alu,
        unit_mul,
        unit_br
    } unit_e;

    typedef struct packed {
        unit_e    unit;
        alu_op_e  alu_op;
        br_cond_e cond;
        logic     src2_imm;
        logic     mul_high;
        logic     mul_signed;
    } uop_t;

    typedef struct packed {
        logic      en;
        uop_t      uop;
        reg_addr_t rd;
        reg_addr_t rj;
        reg_addr_t rk;
        word_t     imm;
        word_t     pc;
        word_t     pc_next;
    } issue_slot_t;

    typedef struct packed {
        logic      en;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    typedef struct packed {
        logic    valid;
        logic    taken;
        br_cat_e category;
        word_t   target;
        word_t   pc;
    } br_res_t;

endpackage

// File: design/exe_forward.sv
`timescale 1ns/1ps

module exe_forward (
    input  exe_pkg::reg_addr_t rj0,
    input  exe_pkg::reg_addr_t rk0,
    input  exe_pkg::reg_addr_t rj1,
    input  exe_pkg::reg_addr_t rk1,
    input  exe_pkg::word_t     rf00,
    input  exe_pkg::word_t     rf01,
    input  exe_pkg::word_t     rf10,
    input  exe_pkg::word_t     rf11,
    input  exe_pkg::wb_t       mid0,
    input  exe_pkg::wb_t       mid1,
    input  exe_pkg::wb_t       wb0,
    input  exe_pkg::wb_t       wb1,
    output exe_pkg::word_t     src00,
    output exe_pkg::word_t     src01,
    output exe_pkg::word_t     src10,
    output exe_pkg::word_t     src11
);

    // newest first: mid1, mid0, wb1, wb0, then the register file
    function automatic exe_pkg::word_t pick(
        input exe_pkg::reg_addr_t addr,
        input exe_pkg::word_t     rf,
        input exe_pkg::wb_t       m1,
        input exe_pkg::wb_t       m0,
        input exe_pkg::wb_t       w1,
        input exe_pkg::wb_t       w0
    );
        if (addr == '0)
            return rf;
        else if (m1.en && m1.rd == addr)
            return m1.data;
        else if (m0.en && m0.rd == addr)
            return m0.data;
        else if (w1.en && w1.rd == addr)
            return w1.data;
        else if (w0.en && w0.rd == addr)
            return w0.data;
        return rf;
    endfunction

    assign src00 = pick(rj0, rf00, mid1, mid0, wb1, wb0);
    assign src01 = pick(rk0, rf01, mid1, mid0, wb1, wb0);
    assign src10 = pick(rj1, rf10, mid1, mid0, wb1, wb0);
    assign src11 = pick(rk1, rf11, mid1, mid0, wb1, wb0);

endmodule

// File: design/exe_alu.sv
`timescale 1ns/1ps

module exe_alu (
    input  exe_pkg::uop_t      uop,
    input  exe_pkg::reg_addr_t rd,
    input  exe_pkg::word_t     src0,
    input  exe_pkg::word_t     src1,
    input  exe_pkg::word_t     imm,
    input  logic               en,
    output exe_pkg::wb_t       res
);

    exe_pkg::word_t op2;
    exe_pkg::word_t result;
    logic [4:0]     shamt;

    assign op2   = uop.src2_imm ? imm : src1;
    assign shamt = op2[4:0];

    always_comb begin
        case (uop.alu_op)
            exe_pkg::alu_add:  result = src0 + op2;
            exe_pkg::alu_sub:  result = src0 - op2;
            exe_pkg::alu_slt:  result = {31'b0, $signed(src0) < $signed(op2)};
            exe_pkg::alu_sltu: result = {31'b0, src0 < op2};
            exe_pkg::alu_and:  result = src0 & op2;
            exe_pkg::alu_or:   result = src0 | op2;
            exe_pkg::alu_nor:  result = ~(src0 | op2);
            exe_pkg::alu_xor:  result = src0 ^ op2;
            exe_pkg::alu_sll:  result = src0 << shamt;
            exe_pkg::alu_srl:  result = src0 >> shamt;
            exe_pkg::alu_sra:  result = exe_pkg::word_t'($signed(src0) >>> shamt);
            // immediate arrives already shifted into place
            exe_pkg::alu_lui:  result = imm;
            default:           result = '0;
        endcase
    end

    assign res.en   = en;
    assign res.rd   = rd;
    assign res.data = result;

endmodule

// File: design/exe_branch.sv
`timescale 1ns/1ps

module exe_branch (
    input  exe_pkg::issue_slot_t slot,
    input  exe_pkg::word_t       src0,
    input  exe_pkg::word_t       src1,
    output exe_pkg::wb_t         link,
    output exe_pkg::br_res_t     res,
    output logic                 mispredict,
    output exe_pkg::word_t       next_pc
);

    exe_pkg::br_cond_e cond;
    exe_pkg::br_cat_e  category;
    exe_pkg::word_t    pc_plus4;
    exe_pkg::word_t    target;
    logic              eq;
    logic              lt_s;
    logic              lt_u;
    logic              taken;

    assign cond     = slot.uop.cond;
    assign pc_plus4 = slot.pc + exe_pkg::link_offset;
    assign eq       = src0 == src1;
    assign lt_s     = $signed(src0) < $signed(src1);
    assign lt_u     = src0 < src1;

    // jirl is register relative, everything else pc relative
    assign target = (cond == exe_pkg::br_jirl) ? src0 + slot.imm : slot.pc + slot.imm;

    always_comb begin
        case (cond)
            exe_pkg::br_jirl, exe_pkg::br_b, exe_pkg::br_bl: taken = 1'b1;
            exe_pkg::br_beq:  taken = eq;
            exe_pkg::br_bne:  taken = !eq;
            exe_pkg::br_blt:  taken = lt_s;
            exe_pkg::br_bge:  taken = !lt_s;
            exe_pkg::br_bltu: taken = lt_u;
            exe_pkg::br_bgeu: taken = !lt_u;
            default:          taken = 1'b0;
        endcase
    end

    always_comb begin
        case (cond)
            exe_pkg::br_bl: category = exe_pkg::cat_call;
            exe_pkg::br_b:  category = exe_pkg::cat_jump;
            exe_pkg::br_jirl: begin
                if (slot.rd == 5'd1)
                    category = exe_pkg::cat_call;
                else if (slot.rj == 5'd1 && slot.rd == 5'd0)
                    category = exe_pkg::cat_return;
                else
                    category = exe_pkg::cat_jump;
            end
            default: category = exe_pkg::cat_cond;
        endcase
    end

    // bl always links to r1
    assign link.en   = slot.en && (cond == exe_pkg::br_bl || cond == exe_pkg::br_jirl);
    assign link.rd   = (cond == exe_pkg::br_bl) ? 5'd1 : slot.rd;
    assign link.data = pc_plus4;

    assign next_pc    = taken ? target : pc_plus4;
    assign mispredict = slot.en && next_pc != slot.pc_next;

    assign res.valid    = slot.en;
    assign res.taken    = slot.en && taken;
    assign res.category = category;
    assign res.target   = target;
    assign res.pc       = slot.pc;

endmodule

// File: design/exe_mul.sv
`timescale 1ns/1ps

module exe_mul (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clear,
    input  logic               en,
    input  exe_pkg::uop_t      uop,
    input  exe_pkg::reg_addr_t rd,
    input  exe_pkg::word_t     src0,
    input  exe_pkg::word_t     src1,
    output exe_pkg::wb_t       res
);

    exe_pkg::word_t     pp_ll;
    exe_pkg::word_t     pp_lh;
    exe_pkg::word_t     pp_hl;
    exe_pkg::word_t     pp_hh;
    exe_pkg::word_t     corr;
    exe_pkg::word_t     pp_ll_q;
    exe_pkg::word_t     pp_lh_q;
    exe_pkg::word_t     pp_hl_q;
    exe_pkg::word_t     pp_hh_q;
    exe_pkg::word_t     corr_q;
    exe_pkg::reg_addr_t rd_q;
    logic               high_q;
    logic               en_q;
    logic [63:0]        product;

    assign pp_ll = src0[15:0] * src1[15:0];
    assign pp_lh = src0[15:0] * src1[31:16];
    assign pp_hl = src0[31:16] * src1[15:0];
    assign pp_hh = src0[31:16] * src1[31:16];

    // signed operands: subtract the sign-weighted other operand from the high word
    assign corr = uop.mul_signed ?
                  32'd0 - (src0[31] ? src1 : 32'd0) - (src1[31] ? src0 : 32'd0) : 32'd0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            en_q <= 1'b0;
        else
            en_q <= en && !clear;
    end

    always_ff @(posedge clk) begin
        pp_ll_q <= pp_ll;
        pp_lh_q <= pp_lh;
        pp_hl_q <= pp_hl;
        pp_hh_q <= pp_hh;
        corr_q  <= corr;
        rd_q    <= rd;
        high_q  <= uop.mul_high;
    end

    // hh and ll do not overlap, middle terms sit at bit 16
    assign product = {pp_hh_q, pp_ll_q} + {16'b0, pp_lh_q, 16'b0}
                   + {16'b0, pp_hl_q, 16'b0} + {corr_q, 32'b0};

    assign res.en   = en_q;
    assign res.rd   = rd_q;
    assign res.data = high_q ? product[63:32] : product[31:0];

endmodule

// File: design/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush_by_writeback,
    input  exe_pkg::issue_slot_t issue0,
    input  exe_pkg::issue_slot_t issue1,
    input  exe_pkg::word_t       rf00,
    input  exe_pkg::word_t       rf01,
    input  exe_pkg::word_t       rf10,
    input  exe_pkg::word_t       rf11,
    output exe_pkg::wb_t         wb0,
    output exe_pkg::wb_t         wb1,
    output exe_pkg::br_res_t     br,
    output logic                 flush,
    output exe_pkg::word_t       correct_pc
);

    logic                 alu_en0;
    logic                 mul_en0;
    logic                 br_en0;
    logic                 kill_mid;
    logic                 mispredict;
    exe_pkg::issue_slot_t br_slot;
    exe_pkg::word_t       src00;
    exe_pkg::word_t       src01;
    exe_pkg::word_t       src10;
    exe_pkg::word_t       src11;
    exe_pkg::word_t       next_pc;
    exe_pkg::wb_t         alu0_res;
    exe_pkg::wb_t         alu1_res;
    exe_pkg::wb_t         link_res;
    exe_pkg::wb_t         mul_res;
    exe_pkg::wb_t         mid0_next;
    exe_pkg::wb_t         wb0_next;
    exe_pkg::wb_t         mid0;
    exe_pkg::wb_t         mid1;
    exe_pkg::br_res_t     br_next;

    assign alu_en0 = issue0.en && issue0.uop.unit == exe_pkg::unit_alu;
    assign mul_en0 = issue0.en && issue0.uop.unit == exe_pkg::unit_mul;
    assign br_en0  = issue0.en && issue0.uop.unit == exe_pkg::unit_br;

    always_comb begin
        br_slot    = issue0;
        br_slot.en = br_en0;
    end

    exe_forward u_forward (
        .rj0   (issue0.rj),
        .rk0   (issue0.rk),
        .rj1   (issue1.rj),
        .rk1   (issue1.rk),
        .rf00  (rf00),
        .rf01  (rf01),
        .rf10  (rf10),
        .rf11  (rf11),
        .mid0  (mid0),
        .mid1  (mid1),
        .wb0   (wb0),
        .wb1   (wb1),
        .src00 (src00),
        .src01 (src01),
        .src10 (src10),
        .src11 (src11)
    );

    exe_alu u_alu0 (
        .uop  (issue0.uop),
        .rd   (issue0.rd),
        .src0 (src00),
        .src1 (src01),
        .imm  (issue0.imm),
        .en   (alu_en0),
        .res  (alu0_res)
    );

    exe_alu u_alu1 (
        .uop  (issue1.uop),
        .rd   (issue1.rd),
        .src0 (src10),
        .src1 (src11),
        .imm  (issue1.imm),
        .en   (issue1.en),
        .res  (alu1_res)
    );

    exe_branch u_branch (
        .slot       (br_slot),
        .src0       (src00),
        .src1       (src01),
        .link       (link_res),
        .res        (br_next),
        .mispredict (mispredict),
        .next_pc    (next_pc)
    );

    exe_mul u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (flush || flush_by_writeback),
        .en    (mul_en0),
        .uop   (issue0.uop),
        .rd    (issue0.rd),
        .src0  (src00),
        .src1  (src01),
        .res   (mul_res)
    );

    // lane 0 units are exclusive, pick whichever is enabled
    always_comb begin
        mid0_next = link_res;
        if (alu0_res.en)
            mid0_next = alu0_res;
        wb0_next = mid0;
        if (mul_res.en)
            wb0_next = mul_res;
    end

    // a redirect kills whatever was issued behind the branch
    assign kill_mid = flush || flush_by_writeback;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mid0       <= '0;
            mid1       <= '0;
            br         <= '0;
            flush      <= 1'b0;
            correct_pc <= '0;
        end else if (kill_mid) begin
            mid0.en  <= 1'b0;
            mid1.en  <= 1'b0;
            br.valid <= 1'b0;
            flush    <= 1'b0;
        end else begin
            mid0       <= mid0_next;
            mid1       <= alu1_res;
            br         <= br_next;
            flush      <= mispredict;
            correct_pc <= next_pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb0 <= '0;
            wb1 <= '0;
        end else if (flush_by_writeback) begin
            wb0.en <= 1'b0;
            wb1.en <= 1'b0;
        end else begin
            wb0 <= wb0_next;
            wb1 <= mid1;
            // lane 1 partner of a mispredicted branch
            if (flush)
                wb1.en <= 1'b0;
        end
    end

endmodule

// File: tests/exe_sva.sv
`timescale 1ns/1ps

module exe_sva (
    input logic             clk,
    input logic             rst_n,
    input exe_pkg::wb_t     wb0,
    input exe_pkg::wb_t     wb1,
    input exe_pkg::br_res_t br,
    input logic             flush
);

    // a redirect only comes from a resolved branch
    a_flush_needs_branch: assert property (
        @(posedge clk) disable iff (!rst_n) flush |-> br.valid
    ) else $error("flush raised without a valid branch");

    a_quiet_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |=> !(wb0.en || wb1.en || br.valid || flush)
    ) else $error("outputs active right after reset release");

    // lane 1 partner of the branch is dropped
    a_partner_killed: assert property (
        @(posedge clk) disable iff (!rst_n) flush |=> !wb1.en
    ) else $error("lane 1 writeback after a redirect");

endmodule

bind exe_stage exe_sva u_sva (
    .clk   (clk),
    .rst_n (rst_n),
    .wb0   (wb0),
    .wb1   (wb1),
    .br    (br),
    .flush (flush)
);

// File: tests/exe_tb.sv
`timescale 1ns/1ps

module exe_tb;

    localparam int max_lines = 64;

    logic                 clk;
    logic                 rst_n;
    logic                 flush_by_writeback;
    exe_pkg::issue_slot_t issue0;
    exe_pkg::issue_slot_t issue1;
    exe_pkg::word_t       rf00;
    exe_pkg::word_t       rf01;
    exe_pkg::word_t       rf10;
    exe_pkg::word_t       rf11;
    exe_pkg::wb_t         wb0;
    exe_pkg::wb_t         wb1;
    exe_pkg::br_res_t     br;
    logic                 flush;
    exe_pkg::word_t       correct_pc;

    logic [63:0]    trace_mem [max_lines][22];
    exe_pkg::word_t shadow_rf [32];
    int             line_count;
    int             errors;
    logic           loaded;
    bit             load_ok;

    exe_stage u_dut (
        .clk                (clk),
        .rst_n              (rst_n),
        .flush_by_writeback (flush_by_writeback),
        .issue0             (issue0),
        .issue1             (issue1),
        .rf00               (rf00),
        .rf01               (rf01),
        .rf10               (rf10),
        .rf11               (rf11),
        .wb0                (wb0),
        .wb1                (wb1),
        .br                 (br),
        .flush              (flush),
        .correct_pc         (correct_pc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            errors++;
            $display("MISMATCH %s got 0x%0h expected 0x%0h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic load_trace(output bit ok);
        int          fd;
        int          n;
        string       text;
        logic [63:0] f [22];
        ok = 1'b0;
        line_count = 0;
        fd = $fopen("tests/exe_trace.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fgets(text, fd) != 0) begin
                if (text.len() > 1 && text[0] != 8'h23) begin
                    n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                                f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17],
                                f[18], f[19], f[20], f[21]);
                    if (n == 22 && line_count < max_lines) begin
                        for (int k = 0; k < 22; k++)
                            trace_mem[line_count][k] = f[k];
                        line_count++;
                    end else begin
                        ok = 1'b0;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_line(input int i);
        exe_pkg::issue_slot_t s0;
        exe_pkg::issue_slot_t s1;
        s0 = '0;
        s1 = '0;
        s0.en      = trace_mem[i][0][0];
        s0.uop     = exe_pkg::uop_t'(trace_mem[i][1][12:0]);
        s0.rd      = trace_mem[i][2][4:0];
        s0.rj      = trace_mem[i][3][4:0];
        s0.rk      = trace_mem[i][4][4:0];
        s0.imm     = trace_mem[i][5][31:0];
        s0.pc      = trace_mem[i][6][31:0];
        s0.pc_next = trace_mem[i][7][31:0];
        s1.en      = trace_mem[i][8][0];
        s1.uop     = exe_pkg::uop_t'(trace_mem[i][9][12:0]);
        s1.rd      = trace_mem[i][10][4:0];
        s1.rj      = trace_mem[i][11][4:0];
        s1.rk      = trace_mem[i][12][4:0];
        s1.imm     = trace_mem[i][13][31:0];
        issue0 = s0;
        issue1 = s1;
        rf00 = shadow_rf[s0.rj];
        rf01 = shadow_rf[s0.rk];
        rf10 = shadow_rf[s1.rj];
        rf11 = shadow_rf[s1.rk];
        flush_by_writeback = trace_mem[i][14][0];
    endtask

    task automatic check_line(input int i);
        logic [63:0] e0;
        logic [63:0] e1;
        logic [63:0] ef;
        e0 = trace_mem[i][15];
        e1 = trace_mem[i][16];
        ef = trace_mem[i][17];
        check_value("wb0.en", 64'(wb0.en), 64'(e0[37]));
        if (e0[37]) begin
            check_value("wb0.rd", 64'(wb0.rd), 64'(e0[36:32]));
            check_value("wb0.data", 64'(wb0.data), 64'(e0[31:0]));
        end
        check_value("wb1.en", 64'(wb1.en), 64'(e1[37]));
        if (e1[37]) begin
            check_value("wb1.rd", 64'(wb1.rd), 64'(e1[36:32]));
            check_value("wb1.data", 64'(wb1.data), 64'(e1[31:0]));
        end
        check_value("br.valid", 64'(br.valid), 64'(ef[3]));
        if (ef[3]) begin
            check_value("br.taken", 64'(br.taken), 64'(ef[2]));
            check_value("br.category", 64'(br.category), 64'(ef[1:0]));
            check_value("br.target", 64'(br.target), 64'(trace_mem[i][18][31:0]));
            check_value("br.pc", 64'(br.pc), 64'(trace_mem[i][19][31:0]));
        end
        check_value("flush", 64'(flush), 64'(trace_mem[i][20][0]));
        if (trace_mem[i][20][0])
            check_value("correct_pc", 64'(correct_pc), 64'(trace_mem[i][21][31:0]));
        // register file write at the end of the cycle, lane 1 is newer
        if (e0[37] && e0[36:32] != 5'd0)
            shadow_rf[e0[36:32]] = e0[31:0];
        if (e1[37] && e1[36:32] != 5'd0)
            shadow_rf[e1[36:32]] = e1[31:0];
    endtask

    task automatic run_trace();
        for (int i = 0; i < line_count; i++) begin
            @(posedge clk);
            #1;
            apply_line(i);
            #2;
            check_line(i);
        end
    endtask

    initial begin
        loaded = 1'b0;
        wait (loaded);
        #((line_count + 16) * 4 + 200);
        $display("watchdog expired, the simulation timed out");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        flush_by_writeback = 1'b0;
        issue0 = '0;
        issue1 = '0;
        rf00 = '0;
        rf01 = '0;
        rf10 = '0;
        rf11 = '0;
        errors = 0;
        // r0 stays zero, others get a per-register pattern
        for (int r = 0; r < 32; r++)
            shadow_rf[r] = 32'(r) * 32'h0101_0101;
        load_trace(load_ok);
        loaded = 1'b1;
        if (!load_ok) begin
            $display("trace file missing or malformed");
            $display("TESTS FAILED");
            $finish;
        end else begin
            repeat (16) @(posedge clk);
            #1;
            rst_n = 1'b1;
            run_trace();
            $display("summary: %0d errors over %0d trace lines", errors, line_count);
            if (errors == 0)
                $display("TESTS PASSED");
            else
                $display("TESTS FAILED");
            $finish;
        end
    end

endmodule

// File: verilog.f
design/exe_pkg.sv
design/exe_forward.sv
design/exe_alu.sv
design/exe_branch.sv
design/exe_mul.sv
design/exe_stage.sv
tests/exe_sva.sv
tests/exe_tb.sv

// File: run.sh
#!/bin/sh
set -e

verilator --binary --timing --assert -f verilog.f --top-module exe_tb -o exe_sim
out=$(./obj_dir/exe_sim)
echo "$out"

if echo "$out" | grep -q "TESTS PASSED"; then
    exit 0
fi
exit 1

// File: tests/exe_trace.txt
# en0 uop0 rd0 rj0 rk0 imm0 pc0 pcnext0 en1 uop1 rd1 rj1 rk1 imm1 fbw
# exp: wb0{en,rd,data} wb1{en,rd,data} br{valid,taken,cat} br_target br_pc flush correct_pc
1 0800 0a 01 02 0 0 0 1 0b84 0b 04 00 ff00 0 0 0 0 0 0 0 0
1 0880 0c 06 01 0 0 0 1 0c04 0d 02 00 4 0 0 0 0 0 0 0 0
1 0800 0e 0c 0d 0 0 0 1 0a80 0f 0a 0b 0 0 2a03030303 2b0404fb04 0 0 0 0 0
1 0804 10 01 00 100 0 0 1 0804 10 02 00 200 0 2c05050505 2d20202020 0 0 0 0 0
1 0800 11 10 00 0 0 0 1 0804 00 02 00 5 0 2e25252525 2f0707fb07 0 0 0 0 0
1 0a80 12 00 07 0 0 0 1 0880 13 10 0f 0 0 3001010201 3002020402 0 0 0 0 0
1 0d84 15 00 00 12345678 0 0 1 0d84 14 00 00 fffffffd 0 3102020402 2002020207 0 0 0 0 0
1 1001 16 14 15 0 0 0 0 0 0 0 0 0 0 3207070707 33fafa08fb 0 0 0 0 0
1 1002 17 14 15 0 0 0 1 0804 18 16 00 0 0 3512345678 34fffffffd 0 0 0 0 0
1 1003 19 14 15 0 0 0 1 0804 1a 16 00 0 0 36c962fc98 0 0 0 0 0 0
1 1830 00 01 01 40 1000 1040 0 0 0 0 0 0 0 3712345677 3816161616 0 0 0 0 0
1 1838 00 01 01 20 1040 1044 0 0 0 0 0 0 0 39ffffffff 3ac962fc98 c 1040 1000 0 0
1 1840 00 14 01 100 1044 1144 0 0 0 0 0 0 0 0 0 8 1060 1040 0 0
1 1850 00 14 01 10 1144 1148 0 0 0 0 0 0 0 0 0 c 1144 1044 0 0
1 1848 00 01 14 fffffff8 1148 1140 0 0 0 0 0 0 0 0 0 8 1154 1144 0 0
1 1858 00 14 01 8 1140 1148 0 0 0 0 0 0 0 0 0 c 1140 1148 0 0
1 1828 00 00 00 400 2000 2400 0 0 0 0 0 0 0 0 0 c 1148 1140 0 0
1 1818 00 01 00 0 2400 2004 0 0 0 0 0 0 0 0 0 e 2400 2000 0 0
1 1818 07 05 00 10 3000 05050515 0 0 0 0 0 0 0 2100002004 0 f 2004 2400 0 0
1 1820 00 00 00 100 4000 4100 0 0 0 0 0 0 0 2000002404 0 d 05050515 3000 0 0
1 1830 00 01 01 80 5000 5004 1 0804 1b 02 00 1 0 2700003004 0 d 4100 4000 0 0
1 0804 1c 02 00 7 0 0 1 0804 1d 03 00 9 0 0 0 c 5080 5000 1 5080
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1000 1c 02 03 0 0 0 1 0804 1d 02 00 1 0 0 0 0 0 0 0 0
1 1000 1e 01 02 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
